//--- hw/spu_macros.svh
`ifndef SPU_MACROS_SVH
`define SPU_MACROS_SVH

// Datapath widths shared by the branch pipe

`define SPU_DATA_W 128			// Full register width
`define SPU_ADDR_W 7			// Register address, 128 entries
`define SPU_PC_W   8			// Program counter width
`define SPU_IMM_W  18			// Widest immediate field
`define SPU_OP_W   11			// Opcode field, left-justified by format
`define SPU_WORD_W 32			// Preferred word size

// Host port and event counters
`define SPU_CFG_W  32			// Host data width
`define SPU_CNT_W  16			// Event counter width, wraps

// Preferred word sits at the top of the register
`define SPU_PREF_HI (`SPU_DATA_W - 1)

`endif

//--- hw/spu_isa_pkg.sv
`include "spu_macros.svh"

package spu_isa_pkg;

	// Instruction formats seen by the branch pipe
	typedef enum logic [2:0] {
		fmt_rr   = 3'd0,			// Register-register form
		fmt_ri16 = 3'd5			// 16-bit immediate form
	} spu_format_e;				// Other codes reserved

	// Branch opcodes, decoded and truncated by format
	// RI16 codes use only the low 9 bits
	typedef enum logic [`SPU_OP_W-1:0] {
		op_nop  = 11'b000_0000_0000,	// No operation
		op_bi   = 11'b001_1010_1000,	// Branch indirect, RR form
		op_brsl = 11'b000_0110_0110,	// Branch relative and set link
		op_br   = 11'b000_0110_0100,	// Branch relative
		op_bra  = 11'b000_0110_0000,	// Branch absolute
		op_brnz = 11'b000_0100_0010,	// Branch if not zero word
		op_brz  = 11'b000_0100_0000	// Branch if zero word
	} spu_op_e;

	// Width of the relative offset inside the immediate
	localparam int unsigned BR_OFS_W = 16;

	// Back-up applied to conditional branch targets
	localparam int unsigned COND_BACKUP = 3;

endpackage

//--- hw/spu_pipe_pkg.sv
`include "spu_macros.svh"

package spu_pipe_pkg;

	import spu_isa_pkg::*;

	// One decoded instruction as it enters the branch pipe
	typedef struct packed {
		logic                   valid;		// Issue strobe, low means nop
		spu_op_e                op;		// Decoded opcode
		spu_format_e            format;	// Instruction format
		logic [`SPU_ADDR_W-1:0] ra_addr;	// Source A address
		logic [`SPU_ADDR_W-1:0] rb_addr;	// Source B address
		logic [`SPU_ADDR_W-1:0] rt_addr;	// Destination / store-source address
		logic [`SPU_IMM_W-1:0]  imm;		// Immediate, truncated by format
		logic                   reg_write;	// Decoder says instr writes rt
		logic                   first;		// First in its issue pair
	} spu_issue_t;

	// Register file read data
	typedef struct packed {
		logic [`SPU_DATA_W-1:0] ra;
		logic [`SPU_DATA_W-1:0] rb;
		logic [`SPU_DATA_W-1:0] rt_st;		// Read at rt_addr
	} spu_operands_t;

	// Result heading back to the register file
	typedef struct packed {
		logic [`SPU_DATA_W-1:0] rt;		// Result value
		logic [`SPU_ADDR_W-1:0] rt_addr;	// Destination
		logic                   reg_write;	// Write enable
	} spu_wb_t;

	// Host register select
	typedef enum logic [1:0] {
		sel_ctrl      = 2'd0,			// Enable bit, write clears counters
		sel_taken_cnt = 2'd1,			// Taken branch count
		sel_kill_cnt  = 2'd2			// Killed twin count
	} spu_cfg_sel_e;

endpackage

//--- hw/spu_reg_file.sv
`timescale 1ns/1ps
`include "spu_macros.svh"

module spu_reg_file (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [`SPU_ADDR_W-1:0]      ra_addr,
	input  logic [`SPU_ADDR_W-1:0]      rb_addr,
	input  logic [`SPU_ADDR_W-1:0]      rt_addr,
	output spu_pipe_pkg::spu_operands_t operands,
	input  spu_pipe_pkg::spu_wb_t       wb
);

	import spu_pipe_pkg::*;

	localparam int unsigned NUM_REGS = 1 << `SPU_ADDR_W;

	logic [`SPU_DATA_W-1:0] regs [NUM_REGS];	// Register array
	logic                   wr_en;			// Qualified write strobe

	// Register 0 stays zero so it can serve as a zero source
	assign wr_en = wb.reg_write && (wb.rt_addr != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;			// Known contents after reset
			end
		end
		else if (wr_en) begin
			regs[wb.rt_addr] <= wb.rt;		// Lands at the edge
		end
	end

	// Three asynchronous read ports
	always_comb begin
		operands.ra    = regs[ra_addr];
		operands.rb    = regs[rb_addr];
		operands.rt_st = regs[rt_addr];		// Store / compare source
	end

	// The branch stage must filter link writes aimed at register 0
	a_no_wr_zero : assert property (
		@(posedge clk) disable iff (reset)
		wb.reg_write |-> (wb.rt_addr != '0)
	) else $error("write-back requested to register 0");

endmodule

//--- hw/spu_pc_unit.sv
`timescale 1ns/1ps
`include "spu_macros.svh"

module spu_pc_unit (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 advance,
	input  logic                 branch_taken,
	input  logic [`SPU_PC_W-1:0] pc_target,
	output logic [`SPU_PC_W-1:0] pc
);

	logic [`SPU_PC_W-1:0] pc_next;			// Next program counter

	always_comb begin
		pc_next = pc;				// Hold by default
		if (branch_taken) begin
			pc_next = pc_target;		// Redirect wins over advance
		end
		else if (advance) begin
			pc_next = pc + 1'b1;		// Wraps at 8 bits
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end
		else begin
			pc <= pc_next;
		end
	end

endmodule

//--- hw/spu_branch_cfg.sv
`timescale 1ns/1ps
`include "spu_macros.svh"

module spu_branch_cfg (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       cfg_we,
	input  spu_pipe_pkg::spu_cfg_sel_e cfg_sel,
	input  logic [`SPU_CFG_W-1:0]      cfg_wdata,
	output logic [`SPU_CFG_W-1:0]      cfg_rdata,
	input  logic                       taken_evt,
	input  logic                       kill_evt,
	output logic                       branch_en
);

	import spu_pipe_pkg::*;

	logic [`SPU_CNT_W-1:0] taken_cnt;		// Taken branch events
	logic [`SPU_CNT_W-1:0] kill_cnt;		// Killed twin events
	logic                  ctrl_wr;		// Host write to control reg

	assign ctrl_wr = cfg_we && (cfg_sel == sel_ctrl);

	// Enable bit, only bit 0 of the control word is stored
	always_ff @(posedge clk) begin
		if (reset) begin
			branch_en <= 1'b0;			// Branches off until host enables
		end
		else if (ctrl_wr) begin
			branch_en <= cfg_wdata[0];
		end
	end

	// Event counters, cleared by any control write
	always_ff @(posedge clk) begin
		if (reset || ctrl_wr) begin
			taken_cnt <= '0;
			kill_cnt  <= '0;
		end
		else begin
			if (taken_evt) taken_cnt <= taken_cnt + 1'b1;	// Wraps
			if (kill_evt)  kill_cnt  <= kill_cnt + 1'b1;
		end
	end

	// Combinational read-back, zero extended
	always_comb begin
		cfg_rdata = '0;
		case (cfg_sel)
			sel_ctrl:      cfg_rdata[0] = branch_en;
			sel_taken_cnt: cfg_rdata[`SPU_CNT_W-1:0] = taken_cnt;
			sel_kill_cnt:  cfg_rdata[`SPU_CNT_W-1:0] = kill_cnt;
			default:       cfg_rdata = '0;	// Unused select reads zero
		endcase
	end

endmodule

//--- hw/spu_branch_unit.sv
`timescale 1ns/1ps
`include "spu_macros.svh"

module spu_branch_unit (
	input  logic                        clk,
	input  logic                        reset,
	input  spu_pipe_pkg::spu_issue_t    issue,
	input  spu_pipe_pkg::spu_operands_t operands,
	input  logic [`SPU_PC_W-1:0]        pc_in,
	input  logic                        branch_en,
	output spu_pipe_pkg::spu_wb_t       wb,
	output logic [`SPU_PC_W-1:0]        pc_target,
	output logic                        branch_taken,
	output logic                        branch_kill,
	output logic                        taken_evt,
	output logic                        kill_evt
);

	import spu_isa_pkg::*;
	import spu_pipe_pkg::*;

	logic [`SPU_WORD_W-1:0] ra_word;		// Preferred word of ra
	logic [`SPU_WORD_W-1:0] rt_word;		// Preferred word of rt_st
	logic [`SPU_WORD_W-1:0] link_word;		// Return address for brsl
	logic [BR_OFS_W-1:0]    ofs;			// Relative offset from imm
	logic [`SPU_PC_W-1:0]   rel_tgt;		// pc_in + offset
	logic [`SPU_PC_W-1:0]   cond_tgt;		// pc_in - 3 + signed offset
	logic                   rt_zero;		// Compare result for brz/brnz
	logic                   live;			// Instr allowed to act

	spu_wb_t                nxt_wb;		// Staged write-back
	logic [`SPU_PC_W-1:0]   nxt_target;		// Staged branch target
	logic                   nxt_taken;		// Staged taken flag

	assign ra_word   = operands.ra[`SPU_PREF_HI -: `SPU_WORD_W];
	assign rt_word   = operands.rt_st[`SPU_PREF_HI -: `SPU_WORD_W];
	assign rt_zero   = (rt_word == '0);
	assign ofs       = issue.imm[BR_OFS_W-1:0];
	assign link_word = `SPU_WORD_W'(pc_in) + 1'b1;	// No 8-bit wrap here

	// Targets wrap to the 8-bit PC, so only the low offset bits matter
	assign rel_tgt  = pc_in + ofs[`SPU_PC_W-1:0];
	assign cond_tgt = pc_in - `SPU_PC_W'(COND_BACKUP) + ofs[`SPU_PC_W-1:0];

	// Squash the twin after a taken branch, and gate off when disabled
	assign live = issue.valid && branch_en && !branch_taken;

	always_comb begin
		nxt_wb     = '0;			// Everything defaults to nop
		nxt_target = '0;
		nxt_taken  = 1'b0;
		if (live) begin
			case (issue.format)
				fmt_rr: begin
					if (issue.op == op_bi) begin
						nxt_target = ra_word[`SPU_PC_W-1:0];
						nxt_taken  = 1'b1;
					end
				end
				fmt_ri16: begin
					case (issue.op)
						op_brsl: begin
							nxt_wb.rt[`SPU_PREF_HI -: `SPU_WORD_W] = link_word;
							nxt_wb.rt_addr   = issue.rt_addr;
							nxt_wb.reg_write = issue.reg_write && (issue.rt_addr != '0);
							nxt_target = rel_tgt;
							nxt_taken  = 1'b1;
						end
						op_br: begin
							nxt_target = rel_tgt;
							nxt_taken  = 1'b1;
						end
						op_bra: begin
							nxt_target = ofs[`SPU_PC_W-1:0];	// Absolute
							nxt_taken  = 1'b1;
						end
						op_brnz, op_brz: begin
							// Taken on a nonzero word for brnz, a zero word for brz
							nxt_taken  = (issue.op == op_brz) ? rt_zero : !rt_zero;
							nxt_target = nxt_taken ? cond_tgt : '0;
						end
						default: ;		// nop and unknown codes
					endcase
				end
				default: ;			// Reserved formats
			endcase
		end
	end

	// Taken branch first in pair kills its twin this cycle
	assign branch_kill = nxt_taken && issue.first;

	// Payload loads every cycle, control state clears on reset
	always_ff @(posedge clk) begin
		wb.rt      <= nxt_wb.rt;
		wb.rt_addr <= nxt_wb.rt_addr;
		pc_target  <= nxt_target;
		if (reset) begin
			branch_taken <= 1'b0;
			wb.reg_write <= 1'b0;
			kill_evt     <= 1'b0;
		end
		else begin
			branch_taken <= nxt_taken;
			wb.reg_write <= nxt_wb.reg_write;
			kill_evt     <= branch_kill;	// One pulse per kill
		end
	end

	assign taken_evt = branch_taken;		// One pulse per taken branch

	// Squash means the twin of a taken branch can never branch
	a_no_back_to_back : assert property (
		@(posedge clk) disable iff (reset)
		branch_taken |=> !branch_taken
	) else $error("taken branch followed by another taken branch");

endmodule

//--- hw/spu_branch_pipe.sv
`timescale 1ns/1ps
`include "spu_macros.svh"

module spu_branch_pipe (
	input  logic                       clk,
	input  logic                       reset,
	input  spu_pipe_pkg::spu_issue_t   issue,
	input  logic                       cfg_we,
	input  spu_pipe_pkg::spu_cfg_sel_e cfg_sel,
	input  logic [`SPU_CFG_W-1:0]      cfg_wdata,
	output logic [`SPU_CFG_W-1:0]      cfg_rdata,
	output logic [`SPU_PC_W-1:0]       pc,
	output spu_pipe_pkg::spu_wb_t      wb,
	output logic                       branch_taken,
	output logic                       branch_kill
);

	import spu_pipe_pkg::*;

	spu_operands_t        operands;		// Register file read data
	logic [`SPU_PC_W-1:0] pc_target;		// Registered branch target
	logic                 branch_en;		// Host enable level
	logic                 taken_evt;		// Counter pulses
	logic                 kill_evt;

	spu_reg_file u_reg_file (
		.clk      (clk),
		.reset    (reset),
		.ra_addr  (issue.ra_addr),
		.rb_addr  (issue.rb_addr),
		.rt_addr  (issue.rt_addr),
		.operands (operands),
		.wb       (wb)				// Result feeds back to its own RF
	);

	spu_pc_unit u_pc_unit (
		.clk          (clk),
		.reset        (reset),
		.advance      (issue.valid),
		.branch_taken (branch_taken),
		.pc_target    (pc_target),
		.pc           (pc)
	);

	spu_branch_cfg u_branch_cfg (
		.clk       (clk),
		.reset     (reset),
		.cfg_we    (cfg_we),
		.cfg_sel   (cfg_sel),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.taken_evt (taken_evt),
		.kill_evt  (kill_evt),
		.branch_en (branch_en)
	);

	spu_branch_unit u_branch_unit (
		.clk          (clk),
		.reset        (reset),
		.issue        (issue),
		.operands     (operands),
		.pc_in        (pc),
		.branch_en    (branch_en),
		.wb           (wb),
		.pc_target    (pc_target),
		.branch_taken (branch_taken),
		.branch_kill  (branch_kill),
		.taken_evt    (taken_evt),
		.kill_evt     (kill_evt)
	);

endmodule

//--- tb/spu_branch_tests.svh
	// One instruction, driven 5 ns after the edge; returns mid-cycle
	task automatic issue_op(input spu_op_e op, input logic [`SPU_ADDR_W-1:0] r,
			input logic [`SPU_IMM_W-1:0] imm, input logic first);
		@(posedge clk);
		#5;
		cfg_we          = 1'b0;
		issue           = '0;
		issue.valid     = (op != op_nop);		// Idle cycles drop valid
		issue.op        = op;
		issue.format    = (op == op_bi) ? fmt_rr : fmt_ri16;
		issue.ra_addr   = r;				// bi reads ra
		issue.rt_addr   = r;				// brz/brnz read rt, brsl writes it
		issue.imm       = imm;
		issue.reg_write = (op == op_brsl);
		issue.first     = first;
		issued_pc       = pc;
		#15;						// Combinational outputs settled
	endtask

	task automatic idle();
		issue_op(op_nop, '0, '0, 1'b0);
	endtask

	task automatic cfg_write(input spu_cfg_sel_e sel, input logic [`SPU_CFG_W-1:0] data);
		@(posedge clk);
		#5;
		issue     = '0;
		cfg_we    = 1'b1;				// Dropped by the next task
		cfg_sel   = sel;
		cfg_wdata = data;
	endtask

	task automatic cfg_read(input spu_cfg_sel_e sel, input logic [`SPU_CFG_W-1:0] want);
		@(posedge clk);
		#5;
		issue   = '0;
		cfg_we  = 1'b0;
		cfg_sel = sel;
		#15;
		if (cfg_rdata !== want) report_mismatch("cfg_rdata", cfg_rdata, want);
	endtask

	// Taken flag one cycle after issue, redirected pc one cycle later
	task automatic expect_branch(input logic [`SPU_PC_W-1:0] tgt);
		idle();
		if (branch_taken !== 1'b1) report_mismatch("branch_taken", branch_taken, 1'b1);
		idle();
		if (pc !== tgt) report_mismatch("pc", pc, tgt);
	endtask

	task automatic test_reset_disable();
		cfg_read(sel_ctrl, '0);
		cfg_read(sel_taken_cnt, '0);
		cfg_read(sel_kill_cnt, '0);
		if (pc !== '0) report_mismatch("pc", pc, '0);
		if (branch_taken !== 1'b0) report_mismatch("branch_taken", branch_taken, 1'b0);
		issue_op(op_br, '0, 18'($urandom), 1'b0);	// Branches still off
		idle();
		if (branch_taken !== 1'b0) report_mismatch("branch_taken", branch_taken, 1'b0);
		if (pc !== 8'd1) report_mismatch("pc", pc, 8'd1);	// Plain increment
	endtask

	task automatic test_direct_targets();
		logic [`SPU_IMM_W-1:0] imm;
		logic [`SPU_PC_W-1:0]  at_pc;
		cfg_write(sel_ctrl, 32'h1);
		imm = 18'($urandom);
		issue_op(op_br, '0, imm, 1'b0);
		expect_branch(model_target(op_br, issued_pc, imm, '0));
		imm = 18'($urandom);
		issue_op(op_bra, '0, imm, 1'b0);
		expect_branch(model_target(op_bra, issued_pc, imm, '0));
		imm = 18'($urandom);
		issue_op(op_brsl, 7'd5, imm, 1'b0);
		at_pc = issued_pc;
		idle();
		if (branch_taken !== 1'b1) report_mismatch("branch_taken", branch_taken, 1'b1);
		if (wb.reg_write !== 1'b1) report_mismatch("wb.reg_write", wb.reg_write, 1'b1);
		if (wb.rt_addr !== 7'd5) report_mismatch("wb.rt_addr", wb.rt_addr, 7'd5);
		if (wb.rt !== {`SPU_WORD_W'(at_pc) + 32'd1, {(`SPU_DATA_W-`SPU_WORD_W){1'b0}}})
			report_mismatch("wb.rt", wb.rt, {`SPU_WORD_W'(at_pc) + 32'd1, 96'b0});
		idle();
		if (pc !== model_target(op_brsl, at_pc, imm, '0))
			report_mismatch("pc", pc, model_target(op_brsl, at_pc, imm, '0));
	endtask

	task automatic test_squash();
		logic [`SPU_IMM_W-1:0] imm;
		logic [`SPU_PC_W-1:0]  tgt;
		for (int i = 0; i < 2; i++) begin
			imm = 18'($urandom);
			issue_op(op_br, '0, imm, 1'b0);
			tgt = model_target(op_br, issued_pc, imm, '0);
			// Twin is a br on the first pass, a link write on the second
			issue_op((i == 0) ? op_br : op_brsl, 7'd9, 18'($urandom), 1'b0);
			if (branch_taken !== 1'b1) report_mismatch("branch_taken", branch_taken, 1'b1);
			idle();
			if (branch_taken !== 1'b0) report_mismatch("branch_taken", branch_taken, 1'b0);
			if (wb.reg_write !== 1'b0) report_mismatch("wb.reg_write", wb.reg_write, 1'b0);
			if (pc !== tgt) report_mismatch("pc", pc, tgt);
		end
	endtask

	task automatic test_cond_indirect();
		logic [`SPU_IMM_W-1:0]  imm;
		logic [`SPU_WORD_W-1:0] link;
		imm = 18'($urandom);
		issue_op(op_brsl, 7'd12, imm, 1'b0);		// r12 gets a nonzero link
		link = `SPU_WORD_W'(issued_pc) + 32'd1;
		expect_branch(model_target(op_brsl, issued_pc, imm, '0));
		issue_op(op_brz, 7'd12, 18'($urandom), 1'b0);	// Falls through
		idle();
		if (branch_taken !== 1'b0) report_mismatch("branch_taken", branch_taken, 1'b0);
		imm = 18'($urandom);
		issue_op(op_brnz, 7'd12, imm, 1'b0);
		expect_branch(model_target(op_brnz, issued_pc, imm, '0));
		imm = 18'($urandom);
		issue_op(op_brz, 7'd0, imm, 1'b0);		// r0 always reads zero
		expect_branch(model_target(op_brz, issued_pc, imm, '0));
		issue_op(op_brnz, 7'd0, 18'($urandom), 1'b0);
		idle();
		if (branch_taken !== 1'b0) report_mismatch("branch_taken", branch_taken, 1'b0);
		issue_op(op_bi, 7'd12, '0, 1'b0);		// Back through the link
		expect_branch(model_target(op_bi, issued_pc, '0, link));
	endtask

	task automatic test_kill_counters();
		cfg_write(sel_ctrl, 32'h1);			// Clears counters, enable stays
		cfg_read(sel_taken_cnt, '0);
		cfg_read(sel_kill_cnt, '0);
		issue_op(op_br, '0, 18'($urandom), 1'b1);	// Taken and first
		if (branch_kill !== 1'b1) report_mismatch("branch_kill", branch_kill, 1'b1);
		issue_op(op_br, '0, 18'($urandom), 1'b1);	// Squashed twin
		if (branch_kill !== 1'b0) report_mismatch("branch_kill", branch_kill, 1'b0);
		issue_op(op_bra, '0, 18'($urandom), 1'b0);	// Taken, second in pair
		if (branch_kill !== 1'b0) report_mismatch("branch_kill", branch_kill, 1'b0);
		idle();
		issue_op(op_brz, '0, 18'($urandom), 1'b1);	// Taken on r0
		if (branch_kill !== 1'b1) report_mismatch("branch_kill", branch_kill, 1'b1);
		idle();
		issue_op(op_brnz, '0, 18'($urandom), 1'b1);	// Not taken on r0
		if (branch_kill !== 1'b0) report_mismatch("branch_kill", branch_kill, 1'b0);
		idle();
		// br, bra and brz taken; br and brz were first
		cfg_read(sel_taken_cnt, 32'd3);
		cfg_read(sel_kill_cnt, 32'd2);
		cfg_write(sel_ctrl, 32'h1);
		cfg_read(sel_taken_cnt, '0);
		cfg_read(sel_kill_cnt, '0);
		cfg_read(sel_ctrl, 32'h1);
	endtask

//--- tb/spu_branch_pipe_tb.sv
`timescale 1ns/1ps
`include "spu_macros.svh"

module spu_branch_pipe_tb;

	import spu_isa_pkg::*;
	import spu_pipe_pkg::*;

	localparam int MAX_CYCLES = 400;		// Directed sequence needs about 70 cycles

	logic                  clk;
	logic                  reset;
	spu_issue_t            issue;
	logic                  cfg_we;
	spu_cfg_sel_e          cfg_sel;
	logic [`SPU_CFG_W-1:0] cfg_wdata;
	logic [`SPU_CFG_W-1:0] cfg_rdata;
	logic [`SPU_PC_W-1:0]  pc;
	spu_wb_t               wb;
	logic                  branch_taken;
	logic                  branch_kill;

	logic [`SPU_PC_W-1:0]  issued_pc;		// pc seen by the latest issue
	int                    errors;
	int                    cycles;

	spu_branch_pipe uut (
		.clk          (clk),
		.reset        (reset),
		.issue        (issue),
		.cfg_we       (cfg_we),
		.cfg_sel      (cfg_sel),
		.cfg_wdata    (cfg_wdata),
		.cfg_rdata    (cfg_rdata),
		.pc           (pc),
		.wb           (wb),
		.branch_taken (branch_taken),
		.branch_kill  (branch_kill)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;			// 40 ns period
	end

	// Watchdog on the whole run
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input logic [`SPU_DATA_W-1:0] got,
			input logic [`SPU_DATA_W-1:0] want);
		errors++;
		$display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
	endtask

	// Reference target rules, all targets cut to the 8-bit pc
	function automatic logic [`SPU_PC_W-1:0] model_target(input spu_op_e op,
			input logic [`SPU_PC_W-1:0] base, input logic [`SPU_IMM_W-1:0] imm,
			input logic [`SPU_WORD_W-1:0] ra_word);
		int t;
		case (op)
			op_bi:          t = int'(ra_word[`SPU_PC_W-1:0]);	// Preferred word of ra
			op_br, op_brsl: t = int'(base) + int'(imm[15:0]);
			op_bra:         t = int'(imm[15:0]);			// Absolute
			default:        t = int'(base) - 3 + int'($signed(imm[15:0]));	// brz, brnz
		endcase
		return t[`SPU_PC_W-1:0];
	endfunction

	`include "spu_branch_tests.svh"

	initial begin
		void'($urandom(32'hf598_f0c0));		// Single seed for the run
		reset     = 1'b1;
		issue     = '0;
		cfg_we    = 1'b0;
		cfg_sel   = sel_ctrl;
		cfg_wdata = '0;
		issued_pc = '0;
		repeat (4) @(posedge clk);
		#5;
		reset = 1'b0;				// Released off the edge
		test_reset_disable();
		test_direct_targets();
		test_squash();
		test_cond_indirect();
		test_kill_counters();
		$display("Run complete: %0d errors in %0d cycles", errors, cycles);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end
		else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+hw
+incdir+tb
hw/spu_isa_pkg.sv
hw/spu_pipe_pkg.sv
hw/spu_reg_file.sv
hw/spu_pc_unit.sv
hw/spu_branch_cfg.sv
hw/spu_branch_unit.sv
hw/spu_branch_pipe.sv
tb/spu_branch_pipe_tb.sv
